// ==== src/zmips_pkg.sv ====
////////////////////////////////////////////////////////////
// zmips shared definitions
// Data widths, instruction field positions, format codes
// and the ALU operation encoding
////////////////////////////////////////////////////////////
`default_nettype none

package zmips_pkg;

    localparam int WORD_W  = 32;        // Data path width
    localparam int REG_AW  = 5;         // Register number width
    localparam int SHAMT_W = 5;         // Barrel shift amount
    localparam int FUNCT_W = 6;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    // Field positions within the instruction word
    localparam int OP_MSB    = 31;
    localparam int OP_LSB    = 26;
    localparam int RS_LSB    = 21;
    localparam int RT_LSB    = 16;
    localparam int RD_LSB    = 11;
    localparam int SHAMT_LSB = 6;
    localparam int FUNCT_LSB = 0;
    localparam int IMM_W     = 26;      // I-format immediate, sign extended

    // Bits of the op field
    localparam int OPB_SHIFT = 0;       // Top bit of the ALU op
    localparam int OPB_FORCE = 1;       // Flags forced from funct ZCN bits
    localparam int OPB_WB    = 2;       // Write result back to rd

    // Flag bits of the funct field, also the flag vector order
    localparam int FNB_Z = 2;
    localparam int FNB_C = 1;
    localparam int FNB_N = 0;

    localparam int PC_STEP = 4;

    // Top two op bits select the format
    typedef enum logic [1:0] {
        FMT_R      = 2'b00,
        FMT_IMM    = 2'b01,         // Load immediate into r0
        FMT_BRANCH = 2'b10,
        FMT_JUMP   = 2'b11
    } fmt_e;

    // {op[0], funct[5:3]}
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_ADC  = 4'b0001,
        ALU_SUB  = 4'b0010,
        ALU_SBC  = 4'b0011,         // a + ~b + carry flag
        ALU_AND  = 4'b0100,
        ALU_OR   = 4'b0101,
        ALU_XOR  = 4'b0110,
        ALU_NOR  = 4'b0111,
        ALU_PASS = 4'b1000,
        ALU_SLL  = 4'b1001,
        ALU_SRL  = 4'b1010,
        ALU_SRA  = 4'b1011
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/zmips_alu.sv ====
////////////////////////////////////////////////////////////
// zmips ALU
// Add and subtract with carry, logic ops, pass and shifts
// with zero and carry outputs
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zmips_alu (
    input  wire zmips_pkg::word_t          a,
    input  wire zmips_pkg::word_t          b,
    input  wire zmips_pkg::alu_op_e        op,
    input  wire [zmips_pkg::SHAMT_W-1:0]   shamt,
    input  wire logic                      cin,
    output zmips_pkg::word_t               y,
    output logic                           zero,
    output logic                           cout
);

    logic                       arith;      // One of the four adder ops
    logic                       sub;
    logic                       c_add;      // Adder carry in
    zmips_pkg::word_t           b_add;
    logic [zmips_pkg::WORD_W:0] sum;        // Extra bit holds carry out

    // Shared adder, subtract is a + ~b + 1
    always_comb begin
        arith = 1'b1;
        sub   = 1'b0;
        c_add = 1'b0;
        case (op)
            zmips_pkg::ALU_ADD: c_add = 1'b0;
            zmips_pkg::ALU_ADC: c_add = cin;
            zmips_pkg::ALU_SUB: begin
                sub   = 1'b1;
                c_add = 1'b1;
            end
            zmips_pkg::ALU_SBC: begin
                sub   = 1'b1;
                c_add = cin;    // Carry is the inverted borrow
            end
            default: arith = 1'b0;
        endcase
    end

    assign b_add = sub ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, b_add} + {{zmips_pkg::WORD_W{1'b0}}, c_add};

    always_comb begin
        case (op)
            zmips_pkg::ALU_AND: y = a & b;
            zmips_pkg::ALU_OR:  y = a | b;
            zmips_pkg::ALU_XOR: y = a ^ b;
            zmips_pkg::ALU_NOR: y = ~(a | b);
            zmips_pkg::ALU_SLL: y = a << shamt;
            zmips_pkg::ALU_SRL: y = a >> shamt;
            zmips_pkg::ALU_SRA: y = zmips_pkg::word_t'($signed(a) >>> shamt);
            default:            y = arith ? sum[zmips_pkg::WORD_W-1:0] : a;    // 1100..1111 pass
        endcase
    end

    assign zero = (y == '0);
    assign cout = arith & sum[zmips_pkg::WORD_W];     // Logic and shift ops give 0

endmodule

`default_nettype wire

// ==== src/zmips_regfile.sv ====
////////////////////////////////////////////////////////////
// zmips register file
// 32 x 32 bit, two combinational read ports, one write
// port with write-through to both reads
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zmips_regfile (
    input  wire logic                 clk,
    input  wire zmips_pkg::reg_addr_t rd_addr_0,
    input  wire zmips_pkg::reg_addr_t rd_addr_1,
    output zmips_pkg::word_t          rd_data_0,
    output zmips_pkg::word_t          rd_data_1,
    input  wire logic                 wr,
    input  wire zmips_pkg::reg_addr_t wr_addr,
    input  wire zmips_pkg::word_t     wr_data
);

    // r0 is writable like any other register
    zmips_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (wr) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Bypass the write in flight so decode sees it this cycle
    function automatic zmips_pkg::word_t read_port(
        input zmips_pkg::reg_addr_t addr,
        input zmips_pkg::word_t     stored,
        input logic                 we,
        input zmips_pkg::reg_addr_t waddr,
        input zmips_pkg::word_t     wdata
    );
        read_port = (we && waddr == addr) ? wdata : stored;
    endfunction

    assign rd_data_0 = read_port(rd_addr_0, regs[rd_addr_0], wr, wr_addr, wr_data);
    assign rd_data_1 = read_port(rd_addr_1, regs[rd_addr_1], wr, wr_addr, wr_data);

endmodule

`default_nettype wire

// ==== src/zmips_fetch_decode.sv ====
////////////////////////////////////////////////////////////
// zmips fetch and decode
// PC, IF/ID instruction register, field split, control
// generation and the ID/EX pipeline register
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zmips_fetch_decode #(
    parameter zmips_pkg::word_t RESET_PC = '0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire zmips_pkg::word_t     i_data,
    output zmips_pkg::word_t          i_addr,
    output zmips_pkg::reg_addr_t      rd_addr_0,
    output zmips_pkg::reg_addr_t      rd_addr_1,
    input  wire zmips_pkg::word_t     rd_data_0,
    input  wire zmips_pkg::word_t     rd_data_1,
    output zmips_pkg::word_t          ex_a,
    output zmips_pkg::word_t          ex_b,
    output zmips_pkg::word_t          ex_imm,
    output zmips_pkg::reg_addr_t      ex_rs,
    output zmips_pkg::reg_addr_t      ex_rt,
    output zmips_pkg::reg_addr_t      ex_rd,
    output zmips_pkg::alu_op_e        ex_alu_op,
    output logic                      ex_use_imm,
    output logic                      ex_wb,
    output logic                      ex_upd_z,
    output logic                      ex_upd_c,
    output logic                      ex_upd_n,
    output logic                      ex_force
);

    zmips_pkg::word_t     pc;
    zmips_pkg::word_t     if_id_ir;         // Zero word is a no-op
    logic [zmips_pkg::OP_MSB-zmips_pkg::OP_LSB:0] op;
    logic [zmips_pkg::FUNCT_W-1:0] funct;
    zmips_pkg::fmt_e      fmt;
    zmips_pkg::reg_addr_t rs, rt, rd;
    zmips_pkg::word_t     imm_se;

    // Decoded controls, registered into ID/EX
    zmips_pkg::reg_addr_t dec_rd;
    zmips_pkg::alu_op_e   dec_op;
    logic dec_use_imm, dec_wb, dec_force;
    logic dec_upd_z, dec_upd_c, dec_upd_n;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc       <= RESET_PC;
            if_id_ir <= '0;
        end else begin
            pc       <= pc + zmips_pkg::word_t'(zmips_pkg::PC_STEP);    // No stalls, no branches
            if_id_ir <= i_data;
        end
    end

    assign i_addr = pc;

    // Split the IR
    assign op     = if_id_ir[zmips_pkg::OP_MSB:zmips_pkg::OP_LSB];
    assign fmt    = zmips_pkg::fmt_e'(if_id_ir[zmips_pkg::OP_MSB -: 2]);
    assign rs     = if_id_ir[zmips_pkg::RS_LSB +: zmips_pkg::REG_AW];
    assign rt     = if_id_ir[zmips_pkg::RT_LSB +: zmips_pkg::REG_AW];
    assign rd     = if_id_ir[zmips_pkg::RD_LSB +: zmips_pkg::REG_AW];
    assign funct  = if_id_ir[zmips_pkg::FUNCT_LSB +: zmips_pkg::FUNCT_W];
    assign imm_se = {{(zmips_pkg::WORD_W-zmips_pkg::IMM_W){if_id_ir[zmips_pkg::IMM_W-1]}},
                     if_id_ir[zmips_pkg::IMM_W-1:0]};

    assign rd_addr_0 = rs;      // Register file answers in the same cycle
    assign rd_addr_1 = rt;

    always_comb begin
        dec_rd      = rd;
        dec_op      = zmips_pkg::alu_op_e'({op[zmips_pkg::OPB_SHIFT], funct[5:3]});
        dec_use_imm = 1'b0;
        dec_wb      = 1'b0;
        dec_force   = 1'b0;
        dec_upd_z   = 1'b0;
        dec_upd_c   = 1'b0;
        dec_upd_n   = 1'b0;
        case (fmt)
            zmips_pkg::FMT_R: begin
                dec_wb    = op[zmips_pkg::OPB_WB];
                dec_force = op[zmips_pkg::OPB_FORCE];
                dec_upd_z = funct[zmips_pkg::FNB_Z];
                dec_upd_c = funct[zmips_pkg::FNB_C];
                dec_upd_n = funct[zmips_pkg::FNB_N];
            end
            zmips_pkg::FMT_IMM: begin
                dec_rd      = '0;               // Immediate always lands in r0
                dec_op      = zmips_pkg::ALU_PASS;
                dec_use_imm = 1'b1;
                dec_wb      = op[zmips_pkg::OPB_WB];   // Bit 28
            end
            zmips_pkg::FMT_BRANCH, zmips_pkg::FMT_JUMP: ;   // Retire as no-ops
        endcase
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        ex_a      <= rd_data_0;
        ex_b      <= rd_data_1;
        ex_imm    <= imm_se;
        ex_rs     <= rs;    // Kept for forwarding compare
        ex_rt     <= rt;
        ex_rd     <= dec_rd;
        ex_alu_op <= dec_op;
    end

    // ID/EX control
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_use_imm <= 1'b0;
            ex_wb      <= 1'b0;
            ex_force   <= 1'b0;
            ex_upd_z   <= 1'b0;
            ex_upd_c   <= 1'b0;
            ex_upd_n   <= 1'b0;
        end else begin
            ex_use_imm <= dec_use_imm;
            ex_wb      <= dec_wb;
            ex_force   <= dec_force;
            ex_upd_z   <= dec_upd_z;
            ex_upd_c   <= dec_upd_c;
            ex_upd_n   <= dec_upd_n;
        end
    end

endmodule

`default_nettype wire

// ==== src/zmips_execute.sv ====
////////////////////////////////////////////////////////////
// zmips execute stage
// Operand forwarding from EX/WB, ALU, ZCN flag register
// and the EX/WB register driving write-back
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zmips_execute (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire zmips_pkg::word_t     ex_a,
    input  wire zmips_pkg::word_t     ex_b,
    input  wire zmips_pkg::word_t     ex_imm,
    input  wire zmips_pkg::reg_addr_t ex_rs,
    input  wire zmips_pkg::reg_addr_t ex_rt,
    input  wire zmips_pkg::reg_addr_t ex_rd,
    input  wire zmips_pkg::alu_op_e   ex_alu_op,
    input  wire logic                 ex_use_imm,
    input  wire logic                 ex_wb,
    input  wire logic                 ex_upd_z,
    input  wire logic                 ex_upd_c,
    input  wire logic                 ex_upd_n,
    input  wire logic                 ex_force,
    output logic                      wb_wr,
    output zmips_pkg::reg_addr_t      wb_addr,
    output zmips_pkg::word_t          wb_data,
    output logic                      flag_z,
    output logic                      flag_c,
    output logic                      flag_n
);

    zmips_pkg::word_t fwd_a, fwd_b;     // After EX/WB bypass
    zmips_pkg::word_t alu_a;
    zmips_pkg::word_t alu_y;
    logic             alu_zero, alu_cout;
    logic [2:0]       flags;            // Indexed by FNB_Z/C/N
    logic [2:0]       upd;
    logic [2:0]       flag_next;

    // Previous instruction still in EX/WB, take its result
    assign fwd_a = (wb_wr && wb_addr == ex_rs) ? wb_data : ex_a;
    assign fwd_b = (wb_wr && wb_addr == ex_rt) ? wb_data : ex_b;
    assign alu_a = ex_use_imm ? ex_imm : fwd_a;     // Immediate load path

    zmips_alu u_alu (
        .a     (alu_a),
        .b     (fwd_b),
        .op    (ex_alu_op),
        .shamt (ex_imm[zmips_pkg::SHAMT_LSB +: zmips_pkg::SHAMT_W]),
        .cin   (flags[zmips_pkg::FNB_C]),
        .y     (alu_y),
        .zero  (alu_zero),
        .cout  (alu_cout)
    );

    always_comb begin
        upd[zmips_pkg::FNB_Z]       = ex_upd_z;
        upd[zmips_pkg::FNB_C]       = ex_upd_c;
        upd[zmips_pkg::FNB_N]       = ex_upd_n;
        flag_next[zmips_pkg::FNB_Z] = alu_zero;
        flag_next[zmips_pkg::FNB_C] = alu_cout;
        flag_next[zmips_pkg::FNB_N] = alu_y[zmips_pkg::WORD_W-1];
        if (ex_force) begin
            flag_next = upd;    // Forced flags take the funct bits themselves
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            flags <= '0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (upd[i] || ex_force) begin
                    flags[i] <= flag_next[i];
                end
            end
        end
    end

    assign flag_z = flags[zmips_pkg::FNB_Z];
    assign flag_c = flags[zmips_pkg::FNB_C];
    assign flag_n = flags[zmips_pkg::FNB_N];

    // EX/WB register
    always_ff @(posedge clk) begin
        if (rst) begin
            wb_wr <= 1'b0;
        end else begin
            wb_wr <= ex_wb;     // One-cycle strobe per writing op
        end
    end

    always_ff @(posedge clk) begin
        wb_addr <= ex_rd;
        wb_data <= alu_y;
    end

endmodule

`default_nettype wire

// ==== src/zmips_core.sv ====
////////////////////////////////////////////////////////////
// zmips core top level
// Three-stage pipeline of fetch/decode, execute and the
// register file
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module zmips_core #(
    parameter zmips_pkg::word_t RESET_PC = '0     // Any word-aligned start address
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire zmips_pkg::word_t     i_data,
    output zmips_pkg::word_t          i_addr,
    output logic                      wb_wr,
    output zmips_pkg::reg_addr_t      wb_addr,
    output zmips_pkg::word_t          wb_data,
    output logic                      flag_z,
    output logic                      flag_c,
    output logic                      flag_n
);

    zmips_pkg::reg_addr_t rd_addr_0, rd_addr_1;
    zmips_pkg::word_t     rd_data_0, rd_data_1;

    // ID/EX outputs
    zmips_pkg::word_t     ex_a, ex_b, ex_imm;
    zmips_pkg::reg_addr_t ex_rs, ex_rt, ex_rd;
    zmips_pkg::alu_op_e   ex_alu_op;
    logic ex_use_imm, ex_wb, ex_force;
    logic ex_upd_z, ex_upd_c, ex_upd_n;

    zmips_fetch_decode #(
        .RESET_PC (RESET_PC)
    ) u_fetch_decode (
        .clk        (clk),
        .rst        (rst),
        .i_data     (i_data),
        .i_addr     (i_addr),
        .rd_addr_0  (rd_addr_0),
        .rd_addr_1  (rd_addr_1),
        .rd_data_0  (rd_data_0),
        .rd_data_1  (rd_data_1),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_rd      (ex_rd),
        .ex_alu_op  (ex_alu_op),
        .ex_use_imm (ex_use_imm),
        .ex_wb      (ex_wb),
        .ex_upd_z   (ex_upd_z),
        .ex_upd_c   (ex_upd_c),
        .ex_upd_n   (ex_upd_n),
        .ex_force   (ex_force)
    );

    // Write port fed straight from EX/WB
    zmips_regfile u_regfile (
        .clk       (clk),
        .rd_addr_0 (rd_addr_0),
        .rd_addr_1 (rd_addr_1),
        .rd_data_0 (rd_data_0),
        .rd_data_1 (rd_data_1),
        .wr        (wb_wr),
        .wr_addr   (wb_addr),
        .wr_data   (wb_data)
    );

    zmips_execute u_execute (
        .clk        (clk),
        .rst        (rst),
        .ex_a       (ex_a),
        .ex_b       (ex_b),
        .ex_imm     (ex_imm),
        .ex_rs      (ex_rs),
        .ex_rt      (ex_rt),
        .ex_rd      (ex_rd),
        .ex_alu_op  (ex_alu_op),
        .ex_use_imm (ex_use_imm),
        .ex_wb      (ex_wb),
        .ex_upd_z   (ex_upd_z),
        .ex_upd_c   (ex_upd_c),
        .ex_upd_n   (ex_upd_n),
        .ex_force   (ex_force),
        .wb_wr      (wb_wr),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .flag_z     (flag_z),
        .flag_c     (flag_c),
        .flag_n     (flag_n)
    );

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
////////////////////////////////////////////////////////////
// Testbench clock and reset source
// Free-running clock, reset held for a fixed cycle count
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 4,     // ns
    parameter int RESET_CYCLES = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released just after a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_checker.sv ====
////////////////////////////////////////////////////////////
// zmips write-back and flag checker
// Compares every register write and the flags against a
// queue of expected results, and tracks the fetch address
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_checker #(
    parameter logic [31:0] RESET_PC = '0
) (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic [31:0] i_addr,
    input wire logic        wb_wr,
    input wire logic [4:0]  wb_addr,
    input wire logic [31:0] wb_data,
    input wire logic        flag_z,
    input wire logic        flag_c,
    input wire logic        flag_n
);

    logic [39:0] exp_q [$];             // {z, c, n, addr, data}
    logic [39:0] exp_e;
    logic [31:0] exp_pc;
    string       test_name      = "none";
    int          n_checks       = 0;
    int          n_errors       = 0;
    logic        seen_wb        = 1'b0;
    logic        flags_reported = 1'b0;

    function void start_test(input string name);
        test_name = name;
    endfunction

    function void expect_write(input logic [4:0] addr, input logic [31:0] data,
                               input logic z, input logic c, input logic n);
        exp_q.push_back({z, c, n, addr, data});
    endfunction

    function int pending_count();
        return exp_q.size();
    endfunction

    // Writes the model expected but the DUT never made
    function void final_check();
        if (exp_q.size() != 0) begin
            $display("%0d expected register writes never appeared on the write-back port",
                     exp_q.size());
            n_errors += exp_q.size();
        end
    endfunction

    // Outputs are all registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            exp_pc = RESET_PC;
        end else begin
            if (i_addr !== exp_pc) begin
                $display("[FAIL] %s i_addr expected %h actual %h", test_name, exp_pc, i_addr);
                n_errors++;
            end
            exp_pc = exp_pc + 32'd4;        // One fetch per cycle
            if (!seen_wb && !flags_reported && {flag_z, flag_c, flag_n} !== 3'b000) begin
                $display("flags not cleared by reset before the first write-back");
                n_errors++;
                flags_reported = 1'b1;
            end
            if (wb_wr === 1'b1) begin
                seen_wb = 1'b1;
                if (exp_q.size() == 0) begin
                    $display("register write to r%0d while no write was expected", wb_addr);
                    n_errors++;
                end else begin
                    exp_e = exp_q.pop_front();
                    n_checks++;
                    if (wb_addr !== exp_e[36:32]) begin
                        $display("[FAIL] %s wb_addr expected %0d actual %0d",
                                 test_name, exp_e[36:32], wb_addr);
                        n_errors++;
                    end
                    if (wb_data !== exp_e[31:0]) begin
                        $display("[FAIL] %s wb_data expected %h actual %h",
                                 test_name, exp_e[31:0], wb_data);
                        n_errors++;
                    end
                    if ({flag_z, flag_c, flag_n} !== exp_e[39:37]) begin   // ZCN order
                        $display("[FAIL] %s flags zcn expected %b actual %b",
                                 test_name, exp_e[39:37], {flag_z, flag_c, flag_n});
                        n_errors++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb/tb_zmips.sv ====
////////////////////////////////////////////////////////////
// zmips core testbench
// Directed and random instruction streams, an in-order
// software model and the cycle limit
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_zmips;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam int N_INIT  = 15;
    localparam int N_IMM   = 6;
    localparam int N_ALU   = 22;
    localparam int N_FLAG  = 8;
    localparam int N_DROP  = 7;
    localparam int N_RAND  = 200;
    localparam int N_DRAIN = 20;
    localparam int N_TOTAL = N_INIT + N_IMM + N_ALU + N_FLAG + N_DROP + N_RAND;
    localparam int LIMIT   = 2 * (10 + N_TOTAL + N_DRAIN);

    logic        clk, rst;
    logic [31:0] i_data;
    logic [31:0] i_addr;
    logic        wb_wr;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic        flag_z, flag_c, flag_n;

    logic [31:0] mregs [32];            // Software register file
    logic        m_z, m_c, m_n;         // Software flags
    logic [31:0] lcg_state;
    int          cycles      = 0;
    int          base_checks = 0;
    int          base_errors = 0;

    tb_clock #(.PERIOD(4), .RESET_CYCLES(10)) u_clock (.clk(clk), .rst(rst));

    zmips_core #(.RESET_PC(RESET_PC)) u_dut (
        .clk(clk), .rst(rst), .i_data(i_data), .i_addr(i_addr),
        .wb_wr(wb_wr), .wb_addr(wb_addr), .wb_data(wb_data),
        .flag_z(flag_z), .flag_c(flag_c), .flag_n(flag_n)
    );

    tb_checker #(.RESET_PC(RESET_PC)) u_checker (
        .clk(clk), .rst(rst), .i_addr(i_addr),
        .wb_wr(wb_wr), .wb_addr(wb_addr), .wb_data(wb_data),
        .flag_z(flag_z), .flag_c(flag_c), .flag_n(flag_n)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // R format: {00, 0, wb, force, op0, rs, rt, rd, shamt, funct}
    function automatic logic [31:0] r_word(input logic wb, input logic frc,
                                           input logic [3:0] code, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [4:0] shamt, input logic [2:0] zcn);
        return {3'b000, wb, frc, code[3], 2'b00, rs, 2'b00, rt, 2'b00, rd,
                shamt, code[2:0], zcn};
    endfunction

    function automatic logic [31:0] imm_word(input logic wb, input logic [25:0] imm);
        return {2'b01, 1'b0, wb, 2'b00, imm};
    endfunction

    // Mostly R format, registers limited to r0..r7 for dense dependencies
    function automatic logic [31:0] rand_word();
        logic [31:0] r;
        logic [31:0] s;
        r = lcg_next();
        s = lcg_next();
        if (r[31:28] < 4'd2) return {2'b01, s[29], r[0] | r[1], s[27:0]};
        if (r[31:28] == 4'd2) return {2'b10, s[29:0]};
        if (r[31:28] == 4'd3) return {2'b11, s[29:0]};
        return r_word(r[20] | r[21] | r[22], r[24] & r[25] & r[26], s[3:0],
                      s[6:4], s[9:7], s[12:10], s[17:13], s[20:18]);
    endfunction

    // In-order execution of one word, returns 1 when it writes a register
    function automatic logic ref_exec(input logic [31:0] w, output logic [4:0] dst,
                                      output logic [31:0] res);
        logic [32:0] wide;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0]  code;
        logic [4:0]  sh;
        logic        wr;
        a    = mregs[w[25:21]];
        b    = mregs[w[20:16]];
        code = {w[26], w[5:3]};
        sh   = w[10:6];
        dst  = w[15:11];
        res  = '0;
        wr   = 1'b0;
        if (w[31:30] == 2'b01) begin                // Immediate into r0
            dst = 5'd0;
            res = {{6{w[25]}}, w[25:0]};
            wr  = w[28];
        end else if (w[31:30] == 2'b00) begin
            case (code)
                zmips_pkg::ALU_ADD: wide = {1'b0, a} + {1'b0, b};
                zmips_pkg::ALU_ADC: wide = {1'b0, a} + {1'b0, b} + {32'd0, m_c};
                zmips_pkg::ALU_SUB: wide = {1'b0, a} + {1'b0, ~b} + 33'd1;
                zmips_pkg::ALU_SBC: wide = {1'b0, a} + {1'b0, ~b} + {32'd0, m_c};
                zmips_pkg::ALU_AND: wide = {1'b0, a & b};
                zmips_pkg::ALU_OR:  wide = {1'b0, a | b};
                zmips_pkg::ALU_XOR: wide = {1'b0, a ^ b};
                zmips_pkg::ALU_NOR: wide = {1'b0, ~(a | b)};
                zmips_pkg::ALU_SLL: wide = {1'b0, a << sh};
                zmips_pkg::ALU_SRL: wide = {1'b0, a >> sh};
                zmips_pkg::ALU_SRA: wide = {1'b0, $signed(a) >>> sh};
                default:            wide = {1'b0, a};       // Pass and unused codes
            endcase
            res = wide[31:0];
            if (w[27]) begin
                {m_z, m_c, m_n} = w[2:0];       // Forced from funct
            end else begin
                if (w[2]) m_z = (res == 32'd0);
                if (w[1]) m_c = (code < 4'd4) ? wide[32] : 1'b0;
                if (w[0]) m_n = res[31];
            end
            wr = w[28];
        end
        if (wr) mregs[dst] = res;
        return wr;
    endfunction

    // Drive one word on the falling edge and queue its expected write
    task automatic issue(input logic [31:0] w);
        logic [4:0]  dst;
        logic [31:0] res;
        logic        wr;
        @(negedge clk);
        i_data = w;
        wr = ref_exec(w, dst, res);
        if (wr) u_checker.expect_write(dst, res, m_z, m_c, m_n);
    endtask

    task automatic finish_test(input string name);
        issue(32'h0);
        do @(posedge clk); while (u_checker.pending_count() != 0);
        $display("test %-12s done: %0d checks, %0d errors", name,
                 u_checker.n_checks - base_checks, u_checker.n_errors - base_errors);
        base_checks = u_checker.n_checks;
        base_errors = u_checker.n_errors;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        i_data    = '0;             // No-ops during reset
        lcg_state = 32'd14897;
        {m_z, m_c, m_n} = 3'b000;
        for (int k = 0; k < 32; k++) mregs[k] = '0;
        u_checker.start_test("reset_fetch");
        @(negedge rst);             // Reset release

        // Give r0..r7 defined values so the model matches
        for (int k = 7; k >= 1; k--) begin
            r = lcg_next();
            issue(imm_word(1'b1, r[31:6]));
            issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_PASS, 3'd0, 3'd0, 3'(k), 5'd0, 3'b000));
        end
        r = lcg_next();
        issue(imm_word(1'b1, r[31:6]));
        finish_test("reset_fetch");

        u_checker.start_test("imm_load");
        issue(imm_word(1'b1, 26'h1FFFFFF));     // Largest positive
        issue(imm_word(1'b1, 26'h2000000));     // Most negative
        issue(imm_word(1'b1, 26'h3FFFFFF));
        issue(imm_word(1'b1, 26'h0000000));
        issue(imm_word(1'b1, 26'h2BCDEF1));
        r = lcg_next();
        issue(imm_word(1'b1, r[25:0]));
        finish_test("imm_load");

        u_checker.start_test("alu_ops");
        issue(imm_word(1'b1, 26'h3FFFFFF));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_SRL, 3'd0, 3'd0, 3'd1, 5'd1, 3'b000));
        issue(imm_word(1'b1, 26'd1));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_PASS, 3'd0, 3'd0, 3'd2, 5'd0, 3'b000));
        issue(imm_word(1'b1, 26'h3FFFFF0));     // -16
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_PASS, 3'd0, 3'd0, 3'd3, 5'd0, 3'b000));
        for (int k = 0; k < 16; k++) begin      // r1 = 7fffffff, r2 = 1, r3 = fffffff0
            issue(r_word(1'b1, 1'b0, 4'(k), 3'd1, k[0] ? 3'd3 : 3'd2, 3'(4 + k % 4),
                         5'd4, 3'b111));
        end
        finish_test("alu_ops");

        u_checker.start_test("flags");
        issue(r_word(1'b0, 1'b0, zmips_pkg::ALU_SUB, 3'd2, 3'd2, 3'd0, 5'd0, 3'b111));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_ADC, 3'd1, 3'd2, 3'd5, 5'd0, 3'b000));
        issue(r_word(1'b0, 1'b1, zmips_pkg::ALU_ADD, 3'd0, 3'd0, 3'd0, 5'd0, 3'b010));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_SBC, 3'd3, 3'd2, 3'd6, 5'd0, 3'b001));
        issue(r_word(1'b0, 1'b1, zmips_pkg::ALU_ADD, 3'd0, 3'd0, 3'd0, 5'd0, 3'b000));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_ADC, 3'd3, 3'd3, 3'd7, 5'd0, 3'b010));
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_SBC, 3'd2, 3'd2, 3'd4, 5'd0, 3'b100));
        issue(r_word(1'b1, 1'b1, zmips_pkg::ALU_XOR, 3'd4, 3'd4, 3'd4, 5'd0, 3'b101));
        finish_test("flags");

        u_checker.start_test("dropped");
        r = lcg_next();
        issue({2'b10, r[29:0]} | 32'h1000_0000);       // Branch with bit 28 set
        r = lcg_next();
        issue({2'b11, r[29:0]} | 32'h1000_0000);       // Jump
        issue(imm_word(1'b0, 26'h1234567));
        issue(r_word(1'b0, 1'b0, zmips_pkg::ALU_ADD, 3'd1, 3'd2, 3'd3, 5'd0, 3'b000));
        issue(r_word(1'b0, 1'b0, zmips_pkg::ALU_SUB, 3'd1, 3'd1, 3'd3, 5'd0, 3'b110));
        r = lcg_next();
        issue({2'b10, r[29:0]});
        issue(r_word(1'b1, 1'b0, zmips_pkg::ALU_OR, 3'd1, 3'd2, 3'd5, 5'd0, 3'b000));
        finish_test("dropped");

        u_checker.start_test("forwarding");
        repeat (N_RAND) issue(rand_word());
        finish_test("forwarding");

        repeat (N_DRAIN) @(posedge clk);    // Catch late stray writes
        u_checker.final_check();
        $display("checks %0d, errors %0d", u_checker.n_checks, u_checker.n_errors);
        if (u_checker.n_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
src/zmips_pkg.sv
src/zmips_alu.sv
src/zmips_regfile.sv
src/zmips_fetch_decode.sv
src/zmips_execute.sv
src/zmips_core.sv
tb/tb_clock.sv
tb/tb_checker.sv
tb/tb_zmips.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the zmips testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --Mdir obj_dir --top-module tb_zmips -f vlog.f

./obj_dir/Vtb_zmips | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation passed"
